/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_wait_buffer
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
wb_pkg.sv
wb_credit_counter.sv
wb_entry_store.sv
wb_rr_arbiter.sv
wait_buffer.sv
wait_buffer_asserts.sv
tb_wait_buffer.sv

/* tb_wait_buffer.sv */
// Table-driven testbench for the wait buffer
// Clock, reset, stimulus loop, reference model of the dispatch rules and checks
`timescale 1ns/1ns

module tb_wait_buffer;
    import wb_pkg::*;

    logic      clk_i = 1'b0;
    logic      arst_n_i;
    logic      inorder_i;
    logic      fe_handshake_i;
    logic      dec_control_decoded_i;
    logic      ib_space_available_o;
    logic      dec_valid_i;
    logic      dec_ready_o;
    dec_req_t  dec_req_i;
    logic      disp_valid_o;
    logic      disp_ready_i;
    disp_req_t disp_req_o;
    logic      opc_read_valid_i;
    tag_t      opc_read_tag_i;
    logic      eu_valid_i;
    tag_t      eu_tag_i;

    // 8 ns period
    always #4 clk_i = ~clk_i;

    wait_buffer i_dut (.*);

    // ##################################################
    // Stimulus table and model state
    // ##################################################

    // Rows 0..3 run out of order, rows 4..7 in order
    dec_req_t   rows[8];
    logic       row_inorder[8];
    int         disp_count[8];
    logic       read_done[8];
    logic       read_sent[8];
    int         read_wait[8];
    logic       woke[NUM_TAGS];
    logic [31:0] lfsr;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    function automatic dec_req_t make_req(input int i, input tag_t tag, input reg_idx_t dst,
                                          input reg_idx_t reg1, input reg_idx_t reg0,
                                          input tag_t otag1, input tag_t otag0,
                                          input opnd_mask_t req, input opnd_mask_t rdy);
        dec_req_t r;
        r.pc                = pc_t'(16'h0100 + i * 4);
        r.inst              = 32'hc0de_0000 | i;
        r.tag               = tag;
        r.dst               = dst;
        r.operands_required = req;
        r.operands_ready    = rdy;
        r.operand_tags      = {otag1, otag0};
        r.operand_regs      = {reg1, reg0};
        return r;
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %-16s %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // ##################################################
    // Reference model for one dispatch
    // ##################################################

    task automatic model_dispatch(input int first, input tag_t tag);
        int r;
        r = -1;
        for (int i = first; i < first + 4; i++) begin
            if (rows[i].tag == tag) begin
                r = i;
            end
        end
        if (r < 0) begin
            $display("error at %0t ns: dispatched tag %0d is not in this batch", $time, tag);
            errors++;
            return;
        end
        check("pc", disp_req_o.pc, rows[r].pc);
        check("inst", disp_req_o.inst, rows[r].inst);
        check("dst", disp_req_o.dst, rows[r].dst);
        check("required", disp_req_o.operands_required, rows[r].operands_required);
        check("regs", disp_req_o.operand_regs, rows[r].operand_regs);
        check("dispatch count before", disp_count[r], 0);
        // Operand wakeup rule
        for (int o = 0; o < OPERANDS; o++) begin
            if (rows[r].operands_required[o] && !rows[r].operands_ready[o]
                && !woke[rows[r].operand_tags[o]]) begin
                $display("error at %0t ns: tag %0d dispatched before its result", $time, tag);
                errors++;
            end
        end
        // Older entries: WAR hazard and in-order mode
        for (int i = first; i < r; i++) begin
            for (int o = 0; o < OPERANDS; o++) begin
                if (!read_done[i] && rows[i].operands_required[o]
                    && rows[i].operand_regs[o] == rows[r].dst) begin
                    $display("error at %0t ns: tag %0d broke WAR order", $time, tag);
                    errors++;
                end
            end
            if (row_inorder[r] && !read_done[i]) begin
                $display("error at %0t ns: tag %0d dispatched out of order", $time, tag);
                errors++;
            end
        end
        disp_count[r]++;
        read_wait[r] = 1 + int'(take_bits(2));
    endtask

    // ##################################################
    // One batch of four instructions
    // ##################################################

    task automatic run_batch(input int first, input tag_t producer, input string name);
        int eb;
        int t;
        int cyc;
        int eu_at;
        logic all_read;
        eb = errors;
        for (int i = 0; i < NUM_TAGS; i++) begin
            woke[i] = 1'b0;
        end
        for (int i = first; i < first + 4; i++) begin
            disp_count[i] = 0;
            read_done[i]  = 1'b0;
            read_sent[i]  = 1'b0;
        end
        // Fill the buffer with dispatch stalled
        @(posedge clk_i);
        disp_ready_i <= 1'b0;
        inorder_i    <= row_inorder[first];
        for (int i = first; i < first + 4; i++) begin
            @(posedge clk_i);
            dec_valid_i <= 1'b1;
            dec_req_i   <= rows[i];
            t = 0;
            do begin
                @(negedge clk_i);
                t++;
            end while (!dec_ready_o && t < 50);
            if (t >= 50) begin
                $display("timeout: decoder handshake never completed");
                errors++;
            end
        end
        @(posedge clk_i);
        dec_valid_i <= 1'b0;
        @(negedge clk_i);
        check("dec_ready_o when full", dec_ready_o, 1'b0);

        // Drain with random back-pressure, results and read reports
        eu_at = 2 + int'(take_bits(3));
        cyc   = 0;
        do begin
            @(posedge clk_i);
            disp_ready_i     <= 1'(take_bits(1));
            eu_valid_i       <= (cyc == eu_at);
            eu_tag_i         <= producer;
            opc_read_valid_i <= 1'b0;
            for (int i = first; i < first + 4; i++) begin
                if (disp_count[i] > 0 && !read_sent[i]) begin
                    read_wait[i]--;
                end
            end
            for (int i = first; i < first + 4; i++) begin
                if (disp_count[i] > 0 && !read_sent[i] && read_wait[i] <= 0) begin
                    read_sent[i]     = 1'b1;
                    opc_read_valid_i <= 1'b1;
                    opc_read_tag_i   <= rows[i].tag;
                    break;
                end
            end
            @(negedge clk_i);
            if (disp_valid_o && disp_ready_i) begin
                model_dispatch(first, disp_req_o.tag);
            end
            // Reports take effect from the next cycle
            if (eu_valid_i) begin
                woke[eu_tag_i] = 1'b1;
            end
            for (int i = first; i < first + 4; i++) begin
                if (opc_read_valid_i && rows[i].tag == opc_read_tag_i) begin
                    read_done[i] = 1'b1;
                end
            end
            all_read = 1'b1;
            for (int i = first; i < first + 4; i++) begin
                all_read &= read_done[i];
            end
            cyc++;
        end while (!all_read && cyc < 300);
        if (!all_read) begin
            $display("timeout: batch %s did not drain", name);
            errors++;
        end
        @(posedge clk_i);
        opc_read_valid_i <= 1'b0;
        eu_valid_i       <= 1'b0;
        disp_ready_i     <= 1'b0;
        @(negedge clk_i);
        check("dec_ready_o after drain", dec_ready_o, 1'b1);
        for (int i = first; i < first + 4; i++) begin
            check("dispatch count", disp_count[i], 1);
        end
        finish_test(name, eb);
    endtask

    // ##################################################
    // Main sequence
    // ##################################################

    initial begin
        int eb;
        lfsr                  = 32'h6ac401ad;
        arst_n_i              = 1'b0;
        inorder_i             = 1'b0;
        fe_handshake_i        = 1'b0;
        dec_control_decoded_i = 1'b0;
        dec_valid_i           = 1'b0;
        dec_req_i             = '0;
        disp_ready_i          = 1'b0;
        opc_read_valid_i      = 1'b0;
        opc_read_tag_i        = '0;
        eu_valid_i            = 1'b0;
        eu_tag_i              = '0;

        // Tag 0 waits on producer 6, tag 1 overwrites reg 10 that tag 0 reads
        rows[0] = make_req(0, 3'd0, 6'd1, 6'd11, 6'd10, 3'd0, 3'd6, 2'b11, 2'b10);
        rows[1] = make_req(1, 3'd1, 6'd10, 6'd12, 6'd13, 3'd0, 3'd0, 2'b11, 2'b11);
        rows[2] = make_req(2, 3'd2, 6'd20, 6'd21, 6'd22, 3'd0, 3'd0, 2'b01, 2'b01);
        rows[3] = make_req(3, 3'd3, 6'd30, 6'd31, 6'd32, 3'd0, 3'd0, 2'b01, 2'b01);
        // In-order batch, the head waits on producer 2
        rows[4] = make_req(4, 3'd4, 6'd40, 6'd41, 6'd42, 3'd2, 3'd0, 2'b11, 2'b01);
        rows[5] = make_req(5, 3'd5, 6'd50, 6'd51, 6'd52, 3'd0, 3'd0, 2'b11, 2'b11);
        rows[6] = make_req(6, 3'd6, 6'd60, 6'd61, 6'd62, 3'd0, 3'd0, 2'b00, 2'b00);
        rows[7] = make_req(7, 3'd7, 6'd70, 6'd71, 6'd72, 3'd0, 3'd0, 2'b10, 2'b10);
        for (int i = 0; i < 8; i++) begin
            row_inorder[i] = (i >= 4);
        end

        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;

        eb = errors;
        @(negedge clk_i);
        check("disp_valid_o after reset", disp_valid_o, 1'b0);
        check("dec_ready_o after reset", dec_ready_o, 1'b1);
        check("space after reset", ib_space_available_o, 1'b1);
        finish_test("reset", eb);

        // Use up every credit, space must hold until the last one goes
        eb = errors;
        for (int i = 0; i < WB_SLOTS; i++) begin
            @(posedge clk_i);
            fe_handshake_i <= 1'b1;
            @(negedge clk_i);
            check("space while credits remain", ib_space_available_o, 1'b1);
        end
        @(posedge clk_i);
        fe_handshake_i <= 1'b0;
        @(negedge clk_i);
        check("space with no credit", ib_space_available_o, 1'b0);
        @(posedge clk_i);
        dec_control_decoded_i <= 1'b1;
        @(posedge clk_i);
        dec_control_decoded_i <= 1'b0;
        @(negedge clk_i);
        check("space after give", ib_space_available_o, 1'b1);
        finish_test("credit", eb);

        run_batch(0, 3'd6, "out_of_order");
        run_batch(4, 3'd2, "in_order");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* wait_buffer.sv */
// Wait buffer top level for one warp
// Connects entry store, round-robin arbiter and fetch credit counter
`timescale 1ns/1ns

module wait_buffer (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Force dispatch in insertion order
    input  logic              inorder_i,
    // Fetch credit
    input  logic              fe_handshake_i,
    input  logic              dec_control_decoded_i,
    output logic              ib_space_available_o,
    // From decoder
    input  logic              dec_valid_i,
    output logic              dec_ready_o,
    input  wb_pkg::dec_req_t  dec_req_i,
    // To operand collector
    output logic              disp_valid_o,
    input  logic              disp_ready_i,
    output wb_pkg::disp_req_t disp_req_o,
    // Operand collector read report
    input  logic              opc_read_valid_i,
    input  wb_pkg::tag_t      opc_read_tag_i,
    // Execution unit result
    input  logic              eu_valid_i,
    input  wb_pkg::tag_t      eu_tag_i
);
    import wb_pkg::*;

    // Store to arbiter
    slot_mask_t                slot_ready;
    disp_req_t  [WB_SLOTS-1:0] slot_reqs;
    // Arbiter back to store and credits
    slot_mask_t                grant;
    logic                      disp_fire;

    wb_entry_store i_store (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .inorder_i        (inorder_i),
        .dec_valid_i      (dec_valid_i),
        .dec_ready_o      (dec_ready_o),
        .dec_req_i        (dec_req_i),
        .eu_valid_i       (eu_valid_i),
        .eu_tag_i         (eu_tag_i),
        .opc_read_valid_i (opc_read_valid_i),
        .opc_read_tag_i   (opc_read_tag_i),
        .grant_i          (grant),
        .slot_ready_o     (slot_ready),
        .slot_reqs_o      (slot_reqs)
    );

    wb_rr_arbiter i_arb (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .slot_ready_i (slot_ready),
        .slot_reqs_i  (slot_reqs),
        .disp_valid_o (disp_valid_o),
        .disp_ready_i (disp_ready_i),
        .disp_req_o   (disp_req_o),
        .grant_o      (grant),
        .disp_fire_o  (disp_fire)
    );

    // Credit back on dispatch or on control instructions that need no slot
    wb_credit_counter i_credit (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .take_i     (fe_handshake_i),
        .dispatch_i (disp_fire),
        .control_i  (dec_control_decoded_i),
        .space_o    (ib_space_available_o)
    );

endmodule

/* wait_buffer_asserts.sv */
// Concurrent checks on the dispatch handshake and grant
// Bound into the wait buffer top level
`timescale 1ns/1ns

module wait_buffer_asserts (
    input logic              clk_i,
    input logic              arst_n_i,
    input wb_pkg::slot_mask_t grant_i,
    input logic              disp_valid_i,
    input logic              disp_ready_i,
    input wb_pkg::disp_req_t disp_req_i
);

    // At most one slot granted
    grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(grant_i))
        else $error("grant is not one-hot");

    // Grant exactly on a completed handshake
    grant_on_fire: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (grant_i != '0) == (disp_valid_i && disp_ready_i))
        else $error("grant does not match the dispatch handshake");

    req_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        disp_valid_i |-> !$isunknown(disp_req_i))
        else $error("dispatched request has unknown bits");

endmodule

bind wait_buffer wait_buffer_asserts i_asserts (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .grant_i      (grant),
    .disp_valid_i (disp_valid_o),
    .disp_ready_i (disp_ready_i),
    .disp_req_i   (disp_req_o)
);

/* wb_credit_counter.sv */
// Fetch credit counter for the wait buffer
// Tells the fetcher whether one more instruction fits
`timescale 1ns/1ns

module wb_credit_counter (
    input  logic clk_i,
    input  logic arst_n_i,
    // Fetch handshake takes a credit
    input  logic take_i,
    // Dispatch or decoded control instruction gives one back
    input  logic dispatch_i,
    input  logic control_i,
    output logic space_o
);
    import wb_pkg::*;

    credit_t count_q;
    logic    give;

    // Either return source frees one credit
    assign give = dispatch_i | control_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Buffer starts empty so all credits are available
            count_q <= CREDIT_MAX;
        end else if (take_i && !give) begin
            // Saturate at zero
            if (count_q != '0) begin
                count_q <= count_q - credit_t'(1);
            end
        end else if (give && !take_i) begin
            // Saturate at the slot count
            if (count_q != CREDIT_MAX) begin
                count_q <= count_q + credit_t'(1);
            end
        end
        // Take and give together cancel out
    end

    assign space_o = (count_q != '0);

endmodule

/* wb_entry_store.sv */
// Wait buffer slot storage
// Insert, dependency capture, operand wakeup, dispatch marking and removal
`timescale 1ns/1ns

module wb_entry_store (
    input  logic                                     clk_i,
    input  logic                                     arst_n_i,
    input  logic                                     inorder_i,
    // Decoder side
    input  logic                                     dec_valid_i,
    output logic                                     dec_ready_o,
    input  wb_pkg::dec_req_t                         dec_req_i,
    // Result and operand read reports
    input  logic                                     eu_valid_i,
    input  wb_pkg::tag_t                             eu_tag_i,
    input  logic                                     opc_read_valid_i,
    input  wb_pkg::tag_t                             opc_read_tag_i,
    // Arbiter side
    input  wb_pkg::slot_mask_t                       grant_i,
    output wb_pkg::slot_mask_t                       slot_ready_o,
    output wb_pkg::disp_req_t [wb_pkg::WB_SLOTS-1:0] slot_reqs_o
);
    import wb_pkg::*;

    // ##################################################
    // Slot state
    // ##################################################

    // Control bits per slot
    slot_mask_t                valid_q, valid_d;
    slot_mask_t                disp_q, disp_d;
    // Older slots each entry still waits on
    slot_mask_t [WB_SLOTS-1:0] dep_q, dep_d;
    opnd_mask_t [WB_SLOTS-1:0] rdy_q, rdy_d;

    // Payload, meaningful only while the slot is valid
    disp_req_t  [WB_SLOTS-1:0]               req_q;
    tag_t       [WB_SLOTS-1:0][OPERANDS-1:0] otag_q;

    // Insert side
    logic       insert;
    slot_mask_t insert_mask;
    slot_mask_t new_dep;
    opnd_mask_t new_rdy;
    disp_req_t  new_req;

    // Slots freed by this cycle's read report
    slot_mask_t remove_mask;

    // Accept while any slot is free
    assign dec_ready_o = ~&valid_q;
    assign insert      = dec_valid_i & dec_ready_o;

    // Lowest free slot takes the new instruction
    always_comb begin : pick_free
        insert_mask = '0;
        for (int s = WB_SLOTS - 1; s >= 0; s--) begin
            if (!valid_q[s]) begin
                insert_mask = slot_mask_t'(1) << s;
            end
        end
    end

    // Read report frees the dispatched slot holding that tag
    always_comb begin : find_remove
        remove_mask = '0;
        for (int s = 0; s < WB_SLOTS; s++) begin
            if (opc_read_valid_i && valid_q[s] && disp_q[s]
                && req_q[s].tag == opc_read_tag_i) begin
                remove_mask[s] = 1'b1;
            end
        end
    end

    // ##################################################
    // New entry
    // ##################################################

    always_comb begin : build_new
        // In-order mode waits on everything already buffered
        new_dep = inorder_i ? valid_q : '0;
        // WAR: wait for older readers of our destination
        for (int s = 0; s < WB_SLOTS; s++) begin
            for (int o = 0; o < OPERANDS; o++) begin
                if (valid_q[s] && req_q[s].operands_required[o]
                    && req_q[s].operand_regs[o] == dec_req_i.dst) begin
                    new_dep[s] = 1'b1;
                end
            end
        end
        // Slots leaving this cycle are no longer a hazard
        new_dep = new_dep & ~remove_mask;

        // Unused operands count as ready, same-cycle results too
        for (int o = 0; o < OPERANDS; o++) begin
            new_rdy[o] = dec_req_i.operands_ready[o] | ~dec_req_i.operands_required[o]
                       | (eu_valid_i && dec_req_i.operand_tags[o] == eu_tag_i);
        end

        new_req.pc                = dec_req_i.pc;
        new_req.inst              = dec_req_i.inst;
        new_req.tag               = dec_req_i.tag;
        new_req.dst               = dec_req_i.dst;
        new_req.operands_required = dec_req_i.operands_required;
        new_req.operand_regs      = dec_req_i.operand_regs;
    end

    // ##################################################
    // Next state
    // ##################################################

    always_comb begin : next_state
        valid_d = valid_q & ~remove_mask;
        // Grant is only set on a completed handshake
        disp_d  = disp_q | grant_i;
        for (int s = 0; s < WB_SLOTS; s++) begin
            dep_d[s] = dep_q[s] & ~remove_mask;
            rdy_d[s] = rdy_q[s];
            // Wakeup on matching result
            for (int o = 0; o < OPERANDS; o++) begin
                if (eu_valid_i && otag_q[s][o] == eu_tag_i) begin
                    rdy_d[s][o] = 1'b1;
                end
            end
            if (insert && insert_mask[s]) begin
                valid_d[s] = 1'b1;
                disp_d[s]  = 1'b0;
                dep_d[s]   = new_dep;
                rdy_d[s]   = new_rdy;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            disp_q  <= '0;
            dep_q   <= '0;
            rdy_q   <= '0;
        end else begin
            valid_q <= valid_d;
            disp_q  <= disp_d;
            dep_q   <= dep_d;
            rdy_q   <= rdy_d;
        end
    end

    // Payload write on insert only
    always_ff @(posedge clk_i) begin
        for (int s = 0; s < WB_SLOTS; s++) begin
            if (insert && insert_mask[s]) begin
                req_q[s]  <= new_req;
                otag_q[s] <= dec_req_i.operand_tags;
            end
        end
    end

    // ##################################################
    // To arbiter
    // ##################################################

    always_comb begin : ready_slots
        for (int s = 0; s < WB_SLOTS; s++) begin
            slot_ready_o[s] = valid_q[s] && !disp_q[s] && (&rdy_q[s]) && (dep_q[s] == '0);
        end
    end

    assign slot_reqs_o = req_q;

endmodule

/* wb_pkg.sv */
// Wait buffer sizes, vector typedefs and request structs
// Shared by the entry store, round-robin arbiter, credit counter and top level
package wb_pkg;

    // ##################################################
    // Sizes
    // ##################################################

    // Slots in the wait buffer of one warp
    localparam int WB_SLOTS = 4;
    // Instruction tags in flight
    localparam int NUM_TAGS = 8;
    // Source operands per instruction
    localparam int OPERANDS = 2;
    localparam int PC_W     = 16;
    localparam int INST_W   = 32;
    localparam int REG_W    = 6;

    // Derived widths
    localparam int TAG_W      = $clog2(NUM_TAGS);
    localparam int SLOT_IDX_W = $clog2(WB_SLOTS);
    // Credit count spans 0..WB_SLOTS inclusive
    localparam int CREDIT_W   = $clog2(WB_SLOTS + 1);

    // ##################################################
    // Vector types
    // ##################################################

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [PC_W-1:0]       pc_t;
    // Instruction word, opaque to the buffer
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_W-1:0]      reg_idx_t;
    typedef logic [OPERANDS-1:0]   opnd_mask_t;
    typedef logic [WB_SLOTS-1:0]   slot_mask_t;
    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;
    typedef logic [CREDIT_W-1:0]   credit_t;

    // Full credit count after reset
    localparam credit_t CREDIT_MAX = credit_t'(WB_SLOTS);

    // ##################################################
    // Request structs
    // ##################################################

    // Decoded instruction from the decoder
    typedef struct packed {
        pc_t                     pc;
        inst_t                   inst;
        tag_t                    tag;
        reg_idx_t                dst;
        opnd_mask_t              operands_required;
        opnd_mask_t              operands_ready;
        tag_t     [OPERANDS-1:0] operand_tags;
        reg_idx_t [OPERANDS-1:0] operand_regs;
    } dec_req_t;

    // Instruction handed to the operand collector
    typedef struct packed {
        pc_t                     pc;
        inst_t                   inst;
        tag_t                    tag;
        reg_idx_t                dst;
        opnd_mask_t              operands_required;
        reg_idx_t [OPERANDS-1:0] operand_regs;
    } disp_req_t;

endpackage

/* wb_rr_arbiter.sv */
// Fair round-robin choice of one ready slot
// Drives the dispatch valid/ready handshake toward the operand collector
`timescale 1ns/1ns

module wb_rr_arbiter (
    input  logic                                     clk_i,
    input  logic                                     arst_n_i,
    input  wb_pkg::slot_mask_t                       slot_ready_i,
    input  wb_pkg::disp_req_t [wb_pkg::WB_SLOTS-1:0] slot_reqs_i,
    // Operand collector side
    output logic                                     disp_valid_o,
    input  logic                                     disp_ready_i,
    output wb_pkg::disp_req_t                        disp_req_o,
    // Back to the store and credit counter
    output wb_pkg::slot_mask_t                       grant_o,
    output logic                                     disp_fire_o
);
    import wb_pkg::*;

    // Last granted slot
    slot_idx_t last_q;
    slot_idx_t pick_idx;
    logic      pick_found;

    // First ready slot after the pointer, wrapping around
    always_comb begin : pick
        slot_idx_t cand;
        cand       = last_q;
        pick_idx   = last_q;
        pick_found = 1'b0;
        for (int k = 1; k <= WB_SLOTS; k++) begin
            cand = slot_idx_t'((int'(last_q) + k) % WB_SLOTS);
            if (!pick_found && slot_ready_i[cand]) begin
                pick_found = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    // No lock-in, so the presented slot may change under back-pressure
    assign disp_valid_o = pick_found;
    assign disp_req_o   = slot_reqs_i[pick_idx];
    assign disp_fire_o  = disp_valid_o & disp_ready_i;

    // One-hot grant only on a completed handshake
    assign grant_o = disp_fire_o ? (slot_mask_t'(1) << pick_idx) : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Slot 0 gets first turn
            last_q <= slot_idx_t'(WB_SLOTS - 1);
        end else if (disp_fire_o) begin
            last_q <= pick_idx;
        end
    end

endmodule
